//--- hdl/frep_pkg.sv
////////////////////
// FREP sequencer shared definitions
// Widths, opcodes, instruction fields and payload types
////////////////////

package frep_pkg;

  // Datapath and storage sizes
  localparam int unsigned data_width = 32;
  localparam int unsigned qid_bits = 5;
  localparam int unsigned buffer_depth = 16;
  localparam int unsigned depth_bits = $clog2(buffer_depth);
  localparam int unsigned loop_iter_bits = 16;
  localparam int unsigned stagger_bits = 3;
  localparam int unsigned reg_bits = 5;

  // Major opcodes seen by the decoder
  localparam logic [6:0] frep_opcode = 7'b0001011;
  localparam logic [6:0] csr_opcode = 7'b1110011;

  // FREP immediate fields
  localparam int unsigned max_inst_lsb = 20;
  localparam int unsigned stagger_max_lsb = 12;
  localparam int unsigned stagger_mask_lsb = 8;

  // Register fields rd, rs1, rs2, rs3 in stagger mask bit order
  localparam int unsigned reg_field_lsb [4] = '{7, 15, 20, 27};

  typedef logic [data_width-1:0] data_t;
  typedef logic [31:0] insn_t;

  typedef struct packed {
    insn_t insn;
    data_t argc;
  } rb_entry_t;

  typedef struct packed {
    logic [qid_bits-1:0] qid;
    insn_t               insn;
    data_t               arga;
    data_t               argb;
    data_t               argc;
    logic                repd;
  } issue_t;

  typedef struct packed {
    logic [depth_bits-1:0]     max_inst;
    logic [loop_iter_bits-1:0] max_iter;
    logic [stagger_bits-1:0]   stagger_max;
    logic [3:0]                stagger_mask;
  } loop_cfg_t;

  typedef enum logic [1:0] {
    path_buffer,
    path_direct,
    path_frep
  } path_e;

endpackage

//--- hdl/offload_if.sv
////////////////////
// Offload instruction stream
// One issue payload with a valid/ready handshake
////////////////////

`timescale 1ns/1ns

interface offload_if;

  // Payload, held stable from valid until the transfer
  frep_pkg::issue_t data;
  logic             valid;
  logic             ready;

  // Producer side
  modport src (
    output data,
    output valid,
    input  ready
  );

  // Consumer side
  modport dst (
    input  data,
    input  valid,
    output ready
  );

endinterface

//--- hdl/frep_decoder.sv
////////////////////
// Instruction decoder
// Sorts each incoming instruction onto the FREP, direct or buffered path
////////////////////

`timescale 1ns/1ns

module frep_decoder (
  input  frep_pkg::insn_t                inp_insn_i,
  input  logic [frep_pkg::qid_bits-1:0]  inp_qid_i,
  input  frep_pkg::data_t                inp_arga_i,
  input  frep_pkg::data_t                inp_argb_i,
  input  frep_pkg::data_t                inp_argc_i,
  input  logic                           inp_valid_i,
  output logic                           inp_ready_o,
  offload_if.src                         direct,
  output logic                           rb_wvalid_o,
  output frep_pkg::rb_entry_t            rb_wdata_o,
  input  logic                           rb_wready_i,
  output logic                           frep_valid_o,
  output frep_pkg::loop_cfg_t            frep_cfg_o,
  input  logic                           frep_ready_i
);

  frep_pkg::path_e path;

  // Only the major opcode matters here
  always_comb begin
    case (inp_insn_i[6:0])
      frep_pkg::frep_opcode: path = frep_pkg::path_frep;
      frep_pkg::csr_opcode:  path = frep_pkg::path_direct;
      default:               path = frep_pkg::path_buffer;
    endcase
  end

  ////////////////////
  // Handshake demux
  ////////////////////

  assign rb_wvalid_o  = inp_valid_i && (path == frep_pkg::path_buffer);
  assign direct.valid = inp_valid_i && (path == frep_pkg::path_direct);
  assign frep_valid_o = inp_valid_i && (path == frep_pkg::path_frep);

  always_comb begin
    case (path)
      frep_pkg::path_frep:   inp_ready_o = frep_ready_i;
      frep_pkg::path_direct: inp_ready_o = direct.ready;
      default:               inp_ready_o = rb_wready_i;
    endcase
  end

  // Buffered entries keep only the instruction and argument C
  assign rb_wdata_o = '{insn: inp_insn_i, argc: inp_argc_i};

  assign direct.data = '{
    qid:  inp_qid_i,
    insn: inp_insn_i,
    arga: inp_arga_i,
    argb: inp_argb_i,
    argc: inp_argc_i,
    repd: 1'b0
  };

  // Loop config fields, iteration count comes from the integer operand
  assign frep_cfg_o = '{
    max_inst:     inp_insn_i[frep_pkg::max_inst_lsb +: frep_pkg::depth_bits],
    max_iter:     inp_arga_i[frep_pkg::loop_iter_bits-1:0],
    stagger_max:  inp_insn_i[frep_pkg::stagger_max_lsb +: frep_pkg::stagger_bits],
    stagger_mask: inp_insn_i[frep_pkg::stagger_mask_lsb +: 4]
  };

endmodule

//--- hdl/ring_buffer.sv
////////////////////
// Ring buffer
// Circular store with random read and multi-entry release
////////////////////

`timescale 1ns/1ns

module ring_buffer #(
  parameter int unsigned depth = 16,
  parameter type entry_t = logic [31:0],
  localparam int unsigned ptr_bits = $clog2(depth),
  localparam int unsigned cnt_bits = $clog2(depth + 1)
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                wvalid_i,
  input  entry_t              wdata_i,
  output logic                wready_o,
  input  logic [ptr_bits-1:0] raddr_i,
  input  logic                advance_i,
  input  logic [cnt_bits-1:0] step_i,
  output entry_t              rdata_o,
  output logic                rvalid_o,
  output logic [ptr_bits-1:0] wptr_o,
  output logic                empty_o
);

  entry_t mem [depth];

  // Filled region runs from fptr_q up to wptr_q
  logic [ptr_bits-1:0] wptr_q;
  logic [ptr_bits-1:0] fptr_q;
  logic [ptr_bits-1:0] offset;
  logic [cnt_bits-1:0] cnt_q;
  logic [cnt_bits-1:0] cnt_d;
  logic                full;
  logic                push;

  assign full     = cnt_q == cnt_bits'(depth);
  assign wready_o = !full;
  assign push     = wvalid_i && wready_o;
  assign empty_o  = cnt_q == '0;
  assign wptr_o   = wptr_q;

  // Read side is combinational
  assign rdata_o  = mem[raddr_i];
  assign offset   = raddr_i - fptr_q;
  assign rvalid_o = cnt_bits'(offset) < cnt_q;

  assign cnt_d = cnt_q + cnt_bits'(push) - (advance_i ? step_i : '0);

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wptr_q <= '0;
      fptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (advance_i) begin
        fptr_q <= fptr_q + step_i[ptr_bits-1:0];
      end
      cnt_q <= cnt_d;
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  // Filled region never exceeds the depth and always ends at the write pointer
  assert property (@(posedge clk_i) disable iff (rst_i)
    (cnt_q <= cnt_bits'(depth)) && (wptr_q == fptr_q + ptr_bits'(cnt_q)))
    else $error("ring buffer write overran the filled region");

  // The reader never releases entries that were not written
  assert property (@(posedge clk_i) disable iff (rst_i)
    advance_i |-> step_i <= cnt_q)
    else $error("ring buffer released more entries than it holds");

endmodule

//--- hdl/frep_sequencer.sv
////////////////////
// FREP sequencer
// Replays buffered loop bodies with staggered register fields
////////////////////

`timescale 1ns/1ns

module frep_sequencer (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              frep_valid_i,
  input  frep_pkg::loop_cfg_t               frep_cfg_i,
  output logic                              frep_ready_o,
  output logic [frep_pkg::depth_bits-1:0]   rb_raddr_o,
  output logic                              rb_advance_o,
  output logic [frep_pkg::depth_bits:0]     rb_step_o,
  input  frep_pkg::rb_entry_t               rb_rdata_i,
  input  logic                              rb_rvalid_i,
  input  logic [frep_pkg::depth_bits-1:0]   rb_wptr_i,
  offload_if.src                            seq
);

  frep_pkg::loop_cfg_t                 cfg_q;
  logic                                cfg_valid_q;
  logic [frep_pkg::depth_bits-1:0]     base_q;
  logic [frep_pkg::depth_bits-1:0]     rd_ptr_q;
  logic [frep_pkg::depth_bits-1:0]     inst_cnt_q;
  logic [frep_pkg::loop_iter_bits-1:0] iter_cnt_q;
  logic [frep_pkg::stagger_bits-1:0]   stagger_cnt_q;
  logic                                loop_run;
  logic                                last_inst;
  logic                                last_iter;
  logic                                issue;
  logic                                rb_full;
  logic [frep_pkg::reg_bits-1:0]       stagger_add;
  frep_pkg::insn_t                     seq_insn;

  // Loop runs once every entry written before the FREP has left
  assign loop_run  = cfg_valid_q && (rd_ptr_q == base_q);
  assign last_inst = inst_cnt_q == cfg_q.max_inst;
  assign last_iter = iter_cnt_q == cfg_q.max_iter;
  assign issue     = seq.valid && seq.ready;

  // Outside a loop rd_ptr_q is the oldest entry, so a hit at wptr means full
  assign rb_full      = (rd_ptr_q == rb_wptr_i) && rb_rvalid_i;
  assign frep_ready_o = !cfg_valid_q && !rb_full;

  ////////////////////
  // Ring buffer access
  ////////////////////

  assign rb_raddr_o   = rd_ptr_q + inst_cnt_q;
  assign rb_step_o    = loop_run ? (frep_pkg::depth_bits + 1)'(cfg_q.max_inst) + 1'b1
                                 : (frep_pkg::depth_bits + 1)'(1);
  // The whole body is freed together after its final issue
  assign rb_advance_o = issue && (!loop_run || (last_inst && last_iter));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cfg_q         <= '0;
      cfg_valid_q   <= 1'b0;
      base_q        <= '0;
      rd_ptr_q      <= '0;
      inst_cnt_q    <= '0;
      iter_cnt_q    <= '0;
      stagger_cnt_q <= '0;
    end else begin
      if (frep_valid_i && frep_ready_o) begin
        cfg_q       <= frep_cfg_i;
        cfg_valid_q <= 1'b1;
        base_q      <= rb_wptr_i;
      end
      if (rb_advance_o) begin
        rd_ptr_q <= rd_ptr_q + rb_step_o[frep_pkg::depth_bits-1:0];
      end
      if (issue && loop_run) begin
        if (!last_inst) begin
          inst_cnt_q <= inst_cnt_q + 1'b1;
        end else if (last_iter) begin
          inst_cnt_q    <= '0;
          iter_cnt_q    <= '0;
          stagger_cnt_q <= '0;
          cfg_valid_q   <= 1'b0;
        end else begin
          // Body wrap, next iteration
          inst_cnt_q    <= '0;
          iter_cnt_q    <= iter_cnt_q + 1'b1;
          stagger_cnt_q <= (stagger_cnt_q == cfg_q.stagger_max) ? '0 : stagger_cnt_q + 1'b1;
        end
      end
    end
  end

  ////////////////////
  // Output composition
  ////////////////////

  assign stagger_add = {{(frep_pkg::reg_bits - frep_pkg::stagger_bits){1'b0}}, stagger_cnt_q};

  // Stagger count is zero outside a loop, so the mask is harmless there
  always_comb begin
    seq_insn = rb_rdata_i.insn;
    for (int i = 0; i < 4; i++) begin
      if (cfg_q.stagger_mask[i]) begin
        seq_insn[frep_pkg::reg_field_lsb[i] +: frep_pkg::reg_bits] =
          rb_rdata_i.insn[frep_pkg::reg_field_lsb[i] +: frep_pkg::reg_bits] + stagger_add;
      end
    end
  end

  assign seq.valid = rb_rvalid_i;
  assign seq.data  = '{
    qid:  '0,
    insn: seq_insn,
    arga: '0,
    argb: '0,
    argc: rb_rdata_i.argc,
    repd: iter_cnt_q != '0
  };

  // Only one loop level, a second FREP must wait for the first to end
  assert property (@(posedge clk_i) disable iff (rst_i)
    cfg_valid_q |-> !frep_valid_i)
    else $error("FREP received while a loop is configured");

endmodule

//--- hdl/offload_arbiter.sv
////////////////////
// Output arbiter
// Direct stream wins only while the ring buffer is empty
////////////////////

`timescale 1ns/1ns

module offload_arbiter (
  input  logic                          clk_i,
  input  logic                          rst_i,
  offload_if.dst                        direct,
  offload_if.dst                        seq,
  input  logic                          rb_empty_i,
  output logic [frep_pkg::qid_bits-1:0] oup_qid_o,
  output frep_pkg::insn_t               oup_insn_o,
  output frep_pkg::data_t               oup_arga_o,
  output frep_pkg::data_t               oup_argb_o,
  output frep_pkg::data_t               oup_argc_o,
  output logic                          oup_repd_o,
  output logic                          oup_valid_o,
  input  logic                          oup_ready_i
);

  frep_pkg::issue_t oup_data;

  assign direct.ready = rb_empty_i && oup_ready_i;
  assign seq.ready    = !rb_empty_i && oup_ready_i;
  assign oup_data     = rb_empty_i ? direct.data : seq.data;
  assign oup_valid_o  = rb_empty_i ? direct.valid : seq.valid;

  // Unpack onto the plain output port
  assign oup_qid_o  = oup_data.qid;
  assign oup_insn_o = oup_data.insn;
  assign oup_arga_o = oup_data.arga;
  assign oup_argb_o = oup_data.argb;
  assign oup_argc_o = oup_data.argc;
  assign oup_repd_o = oup_data.repd;

  // Direct issue never overtakes a pending sequenced entry
  assert property (@(posedge clk_i) disable iff (rst_i)
    direct.valid && direct.ready |-> !seq.valid)
    else $error("direct transfer while a sequenced entry is pending");

  // Stalled output keeps its payload
  assert property (@(posedge clk_i) disable iff (rst_i)
    oup_valid_o && !oup_ready_i |=> oup_valid_o && $stable(oup_data))
    else $error("output changed under back-pressure");

endmodule

//--- hdl/frep_top.sv
////////////////////
// FREP sequencer top level
////////////////////

`timescale 1ns/1ns

module frep_top (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  frep_pkg::insn_t               inp_insn_i,
  input  logic [frep_pkg::qid_bits-1:0] inp_qid_i,
  input  frep_pkg::data_t               inp_arga_i,
  input  frep_pkg::data_t               inp_argb_i,
  input  frep_pkg::data_t               inp_argc_i,
  input  logic                          inp_valid_i,
  output logic                          inp_ready_o,
  output logic [frep_pkg::qid_bits-1:0] oup_qid_o,
  output frep_pkg::insn_t               oup_insn_o,
  output frep_pkg::data_t               oup_arga_o,
  output frep_pkg::data_t               oup_argb_o,
  output frep_pkg::data_t               oup_argc_o,
  output logic                          oup_repd_o,
  output logic                          oup_valid_o,
  input  logic                          oup_ready_i
);

  offload_if direct_if ();
  offload_if seq_if ();

  // Decoder to ring buffer and sequencer
  logic                            rb_wvalid;
  frep_pkg::rb_entry_t             rb_wdata;
  logic                            rb_wready;
  logic                            frep_valid;
  frep_pkg::loop_cfg_t             frep_cfg;
  logic                            frep_ready;

  // Sequencer and ring buffer
  logic [frep_pkg::depth_bits-1:0] rb_raddr;
  logic                            rb_advance;
  logic [frep_pkg::depth_bits:0]   rb_step;
  frep_pkg::rb_entry_t             rb_rdata;
  logic                            rb_rvalid;
  logic [frep_pkg::depth_bits-1:0] rb_wptr;
  logic                            rb_empty;

  frep_decoder i_decoder (
    .inp_insn_i   (inp_insn_i),
    .inp_qid_i    (inp_qid_i),
    .inp_arga_i   (inp_arga_i),
    .inp_argb_i   (inp_argb_i),
    .inp_argc_i   (inp_argc_i),
    .inp_valid_i  (inp_valid_i),
    .inp_ready_o  (inp_ready_o),
    .direct       (direct_if.src),
    .rb_wvalid_o  (rb_wvalid),
    .rb_wdata_o   (rb_wdata),
    .rb_wready_i  (rb_wready),
    .frep_valid_o (frep_valid),
    .frep_cfg_o   (frep_cfg),
    .frep_ready_i (frep_ready)
  );

  ring_buffer #(
    .depth   (frep_pkg::buffer_depth),
    .entry_t (frep_pkg::rb_entry_t)
  ) i_ring_buffer (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wvalid_i  (rb_wvalid),
    .wdata_i   (rb_wdata),
    .wready_o  (rb_wready),
    .raddr_i   (rb_raddr),
    .advance_i (rb_advance),
    .step_i    (rb_step),
    .rdata_o   (rb_rdata),
    .rvalid_o  (rb_rvalid),
    .wptr_o    (rb_wptr),
    .empty_o   (rb_empty)
  );

  frep_sequencer i_sequencer (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .frep_valid_i (frep_valid),
    .frep_cfg_i   (frep_cfg),
    .frep_ready_o (frep_ready),
    .rb_raddr_o   (rb_raddr),
    .rb_advance_o (rb_advance),
    .rb_step_o    (rb_step),
    .rb_rdata_i   (rb_rdata),
    .rb_rvalid_i  (rb_rvalid),
    .rb_wptr_i    (rb_wptr),
    .seq          (seq_if.src)
  );

  offload_arbiter i_arbiter (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .direct      (direct_if.dst),
    .seq         (seq_if.dst),
    .rb_empty_i  (rb_empty),
    .oup_qid_o   (oup_qid_o),
    .oup_insn_o  (oup_insn_o),
    .oup_arga_o  (oup_arga_o),
    .oup_argb_o  (oup_argb_o),
    .oup_argc_o  (oup_argc_o),
    .oup_repd_o  (oup_repd_o),
    .oup_valid_o (oup_valid_o),
    .oup_ready_i (oup_ready_i)
  );

endmodule

//--- testbench/frep_checker.sv
////////////////////
// FREP scoreboard
// Expands input programs into expected issues and compares the output port
////////////////////

`timescale 1ns/1ns

module frep_checker (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  frep_pkg::insn_t               inp_insn_i,
  input  logic [frep_pkg::qid_bits-1:0] inp_qid_i,
  input  frep_pkg::data_t               inp_arga_i,
  input  frep_pkg::data_t               inp_argb_i,
  input  frep_pkg::data_t               inp_argc_i,
  input  logic                          inp_valid_i,
  input  logic                          inp_ready_i,
  input  logic [frep_pkg::qid_bits-1:0] oup_qid_i,
  input  frep_pkg::insn_t               oup_insn_i,
  input  frep_pkg::data_t               oup_arga_i,
  input  frep_pkg::data_t               oup_argb_i,
  input  frep_pkg::data_t               oup_argc_i,
  input  logic                          oup_repd_i,
  input  logic                          oup_valid_i,
  input  logic                          oup_ready_i,
  output int unsigned                   pending_o,
  output int unsigned                   issued_o,
  output int unsigned                   errors_o
);

  frep_pkg::issue_t exp_q [$];
  frep_pkg::issue_t body_q [$];
  int unsigned      body_left;
  int unsigned      max_iter;
  int unsigned      stagger_max;
  logic [3:0]       stagger_mask;

  initial begin
    pending_o = 0;
    issued_o  = 0;
    errors_o  = 0;
    body_left = 0;
  end

  // Register fields rd, rs1, rs2, rs3 each get the stagger count modulo 32
  function automatic frep_pkg::insn_t stagger_insn(input frep_pkg::insn_t insn,
                                                   input int unsigned cnt,
                                                   input logic [3:0] mask);
    frep_pkg::insn_t res;
    res = insn;
    if (mask[0]) res[11:7] = insn[11:7] + 5'(cnt);
    if (mask[1]) res[19:15] = insn[19:15] + 5'(cnt);
    if (mask[2]) res[24:20] = insn[24:20] + 5'(cnt);
    if (mask[3]) res[31:27] = insn[31:27] + 5'(cnt);
    return res;
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp_val,
                             input logic [31:0] got_val);
    if (exp_val !== got_val) begin
      errors_o++;
      $display("ERR %0t %s expected %h got %h", $time, name, exp_val, got_val);
    end
  endtask

  ////////////////////
  // Input side model
  ////////////////////

  task automatic take_input();
    frep_pkg::issue_t item;
    item = '{qid: '0, insn: inp_insn_i, arga: '0, argb: '0, argc: inp_argc_i, repd: 1'b0};
    if (inp_insn_i[6:0] == frep_pkg::frep_opcode) begin
      body_left    = inp_insn_i[23:20] + 1;
      max_iter     = inp_arga_i[15:0];
      stagger_max  = inp_insn_i[14:12];
      stagger_mask = inp_insn_i[11:8];
      body_q.delete();
    end else if (inp_insn_i[6:0] == frep_pkg::csr_opcode) begin
      item.qid  = inp_qid_i;
      item.arga = inp_arga_i;
      item.argb = inp_argb_i;
      exp_q.push_back(item);
    end else begin
      // First iteration streams out as the body arrives
      exp_q.push_back(item);
      if (body_left > 0) begin
        body_q.push_back(item);
        body_left--;
        if (body_left == 0) begin
          for (int unsigned it = 1; it <= max_iter; it++) begin
            foreach (body_q[i]) begin
              item      = body_q[i];
              item.insn = stagger_insn(body_q[i].insn, it % (stagger_max + 1), stagger_mask);
              item.repd = 1'b1;
              exp_q.push_back(item);
            end
          end
        end
      end
    end
  endtask

  task automatic check_output();
    frep_pkg::issue_t exp;
    if (exp_q.size() == 0) begin
      errors_o++;
      $display("Output issue at %0t with no expected issue left", $time);
    end else begin
      exp = exp_q.pop_front();
      issued_o++;
      check_field("oup_qid_o", 32'(exp.qid), 32'(oup_qid_i));
      check_field("oup_insn_o", exp.insn, oup_insn_i);
      check_field("oup_arga_o", exp.arga, oup_arga_i);
      check_field("oup_argb_o", exp.argb, oup_argb_i);
      check_field("oup_argc_o", exp.argc, oup_argc_i);
      check_field("oup_repd_o", 32'(exp.repd), 32'(oup_repd_i));
    end
  endtask

  // Input first, a direct issue leaves in the cycle it arrives
  always @(posedge clk_i) begin
    if (rst_i) begin
      exp_q.delete();
      body_left = 0;
    end else begin
      if (inp_valid_i && inp_ready_i) take_input();
      if (oup_valid_i && oup_ready_i) check_output();
    end
    pending_o = exp_q.size();
  end

endmodule

//--- testbench/tb_frep.sv
////////////////////
// FREP sequencer testbench
// Random programs, output back-pressure and a scoreboard
////////////////////

`timescale 1ns/1ns

module tb_frep;

  logic                          clk_i;
  logic                          rst_i;
  frep_pkg::insn_t               inp_insn_i;
  logic [frep_pkg::qid_bits-1:0] inp_qid_i;
  frep_pkg::data_t               inp_arga_i;
  frep_pkg::data_t               inp_argb_i;
  frep_pkg::data_t               inp_argc_i;
  logic                          inp_valid_i;
  logic                          inp_ready_o;
  logic [frep_pkg::qid_bits-1:0] oup_qid_o;
  frep_pkg::insn_t               oup_insn_o;
  frep_pkg::data_t               oup_arga_o;
  frep_pkg::data_t               oup_argb_o;
  frep_pkg::data_t               oup_argc_o;
  logic                          oup_repd_o;
  logic                          oup_valid_o;
  logic                          oup_ready_i;

  int unsigned pending;
  int unsigned issued;
  int unsigned chk_errors;
  int unsigned tb_errors;
  int unsigned sent;
  int unsigned cycles;
  int unsigned ready_pct;
  int unsigned test_idx;
  int unsigned last_issued;
  int unsigned last_errors;

  frep_top dut (.*);

  frep_checker i_checker (
    .clk_i(clk_i), .rst_i(rst_i),
    .inp_insn_i(inp_insn_i), .inp_qid_i(inp_qid_i), .inp_arga_i(inp_arga_i),
    .inp_argb_i(inp_argb_i), .inp_argc_i(inp_argc_i),
    .inp_valid_i(inp_valid_i), .inp_ready_i(inp_ready_o),
    .oup_qid_i(oup_qid_o), .oup_insn_i(oup_insn_o), .oup_arga_i(oup_arga_o),
    .oup_argb_i(oup_argb_o), .oup_argc_i(oup_argc_o), .oup_repd_i(oup_repd_o),
    .oup_valid_i(oup_valid_o), .oup_ready_i(oup_ready_i),
    .pending_o(pending), .issued_o(issued), .errors_o(chk_errors)
  );

  always #4 clk_i = ~clk_i;

  // Random output back-pressure
  always @(negedge clk_i) begin
    if (!rst_i) oup_ready_i <= ($urandom_range(99) < ready_pct);
  end

  // Watchdog, budget grows with every instruction sent
  always @(posedge clk_i) begin
    cycles++;
    if (cycles > 200 * sent + 2000) begin
      $display("Timeout after %0d cycles with %0d instructions sent", cycles, sent);
      $display("Something failed");
      $finish;
    end
  end

  task automatic send(input frep_pkg::insn_t insn, input frep_pkg::data_t arga);
    inp_insn_i  = insn;
    inp_qid_i   = 5'($urandom);
    inp_arga_i  = arga;
    inp_argb_i  = $urandom;
    inp_argc_i  = $urandom;
    inp_valid_i = 1'b1;
    @(posedge clk_i);
    while (!inp_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    inp_valid_i = 1'b0;
    sent++;
  endtask

  // Any opcode but FREP and CSR goes to the buffer
  task automatic send_plain();
    frep_pkg::insn_t insn;
    insn = $urandom;
    if (insn[6:0] == frep_pkg::frep_opcode || insn[6:0] == frep_pkg::csr_opcode)
      insn[6:0] = 7'b1010011;
    send(insn, $urandom);
  endtask

  task automatic send_direct();
    frep_pkg::insn_t insn;
    insn      = $urandom;
    insn[6:0] = frep_pkg::csr_opcode;
    send(insn, $urandom);
  endtask

  task automatic wait_drain();
    @(negedge clk_i);
    while (pending != 0) @(negedge clk_i);
  endtask

  // A new loop only once the previous one has fully left
  task automatic send_loop(input int unsigned max_inst, input int unsigned max_iter,
                           input int unsigned smax, input int unsigned mask);
    frep_pkg::insn_t insn;
    wait_drain();
    insn        = $urandom;
    insn[6:0]   = frep_pkg::frep_opcode;
    insn[23:20] = max_inst[3:0];
    insn[14:12] = smax[2:0];
    insn[11:8]  = mask[3:0];
    send(insn, {16'h0, max_iter[15:0]});
    repeat (max_inst + 1) send_plain();
  endtask

  task automatic finish_test(input string name);
    wait_drain();
    test_idx++;
    $display("Test %0d %s done: %0d issues, %0d errors", test_idx, name,
             issued - last_issued, chk_errors + tb_errors - last_errors);
    last_issued = issued;
    last_errors = chk_errors + tb_errors;
  endtask

  initial begin
    void'($urandom(26741));
    clk_i = 1'b0;
    rst_i = 1'b1;
    inp_insn_i = '0;
    inp_qid_i = '0;
    inp_arga_i = '0;
    inp_argb_i = '0;
    inp_argc_i = '0;
    inp_valid_i = 1'b0;
    oup_ready_i = 1'b0;
    sent = 0;
    cycles = 0;
    tb_errors = 0;
    test_idx = 0;
    last_issued = 0;
    last_errors = 0;
    ready_pct = 75;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    if (oup_valid_o !== 1'b0) begin
      tb_errors++;
      $display("ERR %0t oup_valid_o expected 0 got %b", $time, oup_valid_o);
    end
    // Empty buffer takes a buffered instruction right away
    if (inp_ready_o !== 1'b1) begin
      tb_errors++;
      $display("ERR %0t inp_ready_o expected 1 got %b", $time, inp_ready_o);
    end

    repeat (20) send_plain();
    finish_test("straight-line");

    repeat (24) begin
      if ($urandom_range(2) == 0) send_direct();
      else send_plain();
    end
    finish_test("direct");

    repeat (4) begin
      send_loop($urandom_range(7), $urandom_range(5), 0, 0);
      repeat ($urandom_range(3)) send_plain();
    end
    finish_test("loop");

    repeat (4) begin
      send_loop($urandom_range(7), $urandom_range(5), $urandom_range(7), $urandom_range(15));
      send_plain();
      send_direct();
    end
    finish_test("stagger");

    // Slow drain so the buffer fills and stalls the input
    ready_pct = 15;
    send_loop(7, $urandom_range(5), $urandom_range(7), $urandom_range(15));
    repeat (12) send_plain();
    repeat (2) send_direct();
    wait_drain();
    repeat (4) begin
      @(negedge clk_i);
      if (oup_valid_o !== 1'b0) begin
        tb_errors++;
        $display("ERR %0t oup_valid_o expected 0 got %b", $time, oup_valid_o);
      end
    end
    finish_test("back-pressure");

    $display("Summary: %0d tests, %0d issues checked, %0d errors", test_idx, issued,
             chk_errors + tb_errors);
    if (chk_errors + tb_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- compile.f
hdl/frep_pkg.sv
hdl/offload_if.sv
hdl/frep_decoder.sv
hdl/ring_buffer.sv
hdl/frep_sequencer.sv
hdl/offload_arbiter.sv
hdl/frep_top.sv
testbench/frep_checker.sv
testbench/tb_frep.sv

//--- Bender.yml
package:
  name: frep_sequencer

sources:
  - hdl/frep_pkg.sv
  - hdl/offload_if.sv
  - hdl/frep_decoder.sv
  - hdl/ring_buffer.sv
  - hdl/frep_sequencer.sv
  - hdl/offload_arbiter.sv
  - hdl/frep_top.sv
  - target: test
    files:
      - testbench/frep_checker.sv
      - testbench/tb_frep.sv
